// ==== src/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// memory geometry
// ~~~~~~~~~~~~~~~~~~~~

`define MEM_WORDS_LOG2 10   // 1024 words, index from addr[11:2]

// ~~~~~~~~~~~~~~~~~~~~
// reset handling
// ~~~~~~~~~~~~~~~~~~~~

`define CLEAR_CYCLES 2      // requests dropped this long after reset

// ~~~~~~~~~~~~~~~~~~~~
// board LEDs
// ~~~~~~~~~~~~~~~~~~~~

`define LED_ADDR_LSB 3      // shows addr[18:3]
`define LED_WIDTH 16

`endif

// ==== src/mem_pkg.sv ====
`include "mem_macros.svh"

package mem_pkg;

  // byte address from the CPU bus
  typedef logic [31:0] addr_type;

  // data word, read and write
  typedef logic [31:0] word_type;

  // one bit per byte lane; all zero means read
  typedef logic [3:0] strb_type;

  // address field mirrored on the LEDs
  typedef logic [`LED_WIDTH-1:0] led_type;

  // in-flight requests, never more than four
  typedef logic [2:0] cnt_type;

endpackage

// ==== src/mem_request_stage.sv ====
`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_request_stage (
  input  logic              CLOCK_CPU,
  input  logic              RESET,
  input  logic              mem_valid,
  input  mem_pkg::addr_type mem_addr,
  input  mem_pkg::word_type mem_wdata,
  input  mem_pkg::strb_type mem_wstrb,
  output logic              issue_valid,
  output mem_pkg::addr_type issue_addr,
  output mem_pkg::word_type issue_wdata,
  output mem_pkg::strb_type issue_wstrb,
  output mem_pkg::led_type  led
);

  import mem_pkg::*;

  logic [`CLEAR_CYCLES-1:0] clear;
  logic                     accept;
  led_type                  led_next;

  // ~~~~~~~~~~~~~~~~~~~~
  // clear window
  // ~~~~~~~~~~~~~~~~~~~~

  // loaded with ones on reset, shifts a zero in each cycle
  always_ff @(posedge CLOCK_CPU) begin
    if (RESET == 0) begin
      clear <= '1;
    end else begin
      clear <= {1'b0, clear[`CLEAR_CYCLES-1:1]};
    end
  end

  assign accept = mem_valid & ~clear[0];  // drop while window open

  // ~~~~~~~~~~~~~~~~~~~~
  // request register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CLOCK_CPU) begin
    if (RESET == 0) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= accept;
    end
  end

  // payload only, follows the valid bit
  always_ff @(posedge CLOCK_CPU) begin
    if (accept) begin
      issue_addr  <= mem_addr;
      issue_wdata <= mem_wdata;
      issue_wstrb <= mem_wstrb;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // LED capture
  // ~~~~~~~~~~~~~~~~~~~~

  assign led_next = mem_addr[`LED_ADDR_LSB +: `LED_WIDTH];

  always_ff @(posedge CLOCK_CPU) begin
    if (RESET == 0) begin
      led <= '0;
    end else begin
      if (accept) begin
        led <= led_next;  // last accepted address
      end
    end
  end

endmodule

// ==== src/mem_bank.sv ====
`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_bank (
  input  logic              CLOCK_CPU,
  input  logic              RESET,
  input  logic              issue_valid,
  input  mem_pkg::addr_type issue_addr,
  input  mem_pkg::word_type issue_wdata,
  input  mem_pkg::strb_type issue_wstrb,
  output logic              bank_valid,
  output mem_pkg::word_type bank_rdata
);

  import mem_pkg::*;

  localparam int WORDS = 1 << `MEM_WORDS_LOG2;

  word_type mem_array [WORDS];

  logic [`MEM_WORDS_LOG2-1:0] word_idx;
  logic                       is_write;

  logic     s1_valid;
  word_type s1_rdata;

  // bits above 11 alias onto the same words
  assign word_idx = issue_addr[`MEM_WORDS_LOG2+1:2];
  assign is_write = |issue_wstrb;

  // ~~~~~~~~~~~~~~~~~~~~
  // word array
  // ~~~~~~~~~~~~~~~~~~~~

  // write at issue so a following read sees it
  always_ff @(posedge CLOCK_CPU) begin
    if (issue_valid && is_write) begin
      for (int b = 0; b < 4; b++) begin
        if (issue_wstrb[b]) begin
          mem_array[word_idx][b*8 +: 8] <= issue_wdata[b*8 +: 8];
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // read pipeline
  // ~~~~~~~~~~~~~~~~~~~~

  // stage 1 latches the word, writes answer zero
  always_ff @(posedge CLOCK_CPU) begin
    if (issue_valid) begin
      if (is_write) begin
        s1_rdata <= '0;
      end else begin
        s1_rdata <= mem_array[word_idx];
      end
    end
  end

  // stage 2 drives the response
  always_ff @(posedge CLOCK_CPU) begin
    if (s1_valid) begin
      bank_rdata <= s1_rdata;
    end
  end

  // one valid bit per stage, two items in flight at most
  always_ff @(posedge CLOCK_CPU) begin
    if (RESET == 0) begin
      s1_valid   <= 1'b0;
      bank_valid <= 1'b0;
    end else begin
      s1_valid   <= issue_valid;
      bank_valid <= s1_valid;
    end
  end

endmodule

// ==== src/mem_response_stage.sv ====
`timescale 1ns/1ps

module mem_response_stage (
  input  logic              CLOCK_CPU,
  input  logic              RESET,
  input  logic              issue_valid,
  input  logic              bank_valid,
  input  mem_pkg::word_type bank_rdata,
  output logic              mem_ready,
  output mem_pkg::word_type mem_rdata,
  output logic              busy
);

  import mem_pkg::*;

  cnt_type inflight;

  // ~~~~~~~~~~~~~~~~~~~~
  // bus response
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CLOCK_CPU) begin
    if (RESET == 0) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= bank_valid;  // single-cycle strobe
    end
  end

  always_ff @(posedge CLOCK_CPU) begin
    if (bank_valid) begin
      mem_rdata <= bank_rdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // in-flight count
  // ~~~~~~~~~~~~~~~~~~~~

  // up on issue, down as the response leaves
  always_ff @(posedge CLOCK_CPU) begin
    if (RESET == 0) begin
      inflight <= '0;
    end else begin
      case ({issue_valid, mem_ready})
        2'b10:   inflight <= inflight + cnt_type'(1);
        2'b01:   inflight <= inflight - cnt_type'(1);
        default: inflight <= inflight;  // none, or both at once
      endcase
    end
  end

  // issue_valid covers the cycle before the count catches up
  assign busy = issue_valid | (inflight != '0);

endmodule

// ==== src/mem_system.sv ====
`timescale 1ns/1ps

module mem_system (
  input  logic              CLOCK_CPU,
  input  logic              RESET,
  input  logic              mem_valid,
  input  logic              mem_instr,
  input  mem_pkg::addr_type mem_addr,
  input  mem_pkg::word_type mem_wdata,
  input  mem_pkg::strb_type mem_wstrb,
  output logic              mem_ready,
  output mem_pkg::word_type mem_rdata,
  output mem_pkg::led_type  led,
  output logic              busy
);

  import mem_pkg::*;

  // request stage to bank
  logic     issue_valid;
  addr_type issue_addr;
  word_type issue_wdata;
  strb_type issue_wstrb;

  // bank to response stage
  logic     bank_valid;
  word_type bank_rdata;

  // ~~~~~~~~~~~~~~~~~~~~
  // input side
  // ~~~~~~~~~~~~~~~~~~~~

  // mem_instr has no effect on the memory, left open
  mem_request_stage request_stage0 (
    .CLOCK_CPU   (CLOCK_CPU),
    .RESET       (RESET),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .issue_valid (issue_valid),
    .issue_addr  (issue_addr),
    .issue_wdata (issue_wdata),
    .issue_wstrb (issue_wstrb),
    .led         (led)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // word memory
  // ~~~~~~~~~~~~~~~~~~~~

  mem_bank bank0 (
    .CLOCK_CPU   (CLOCK_CPU),
    .RESET       (RESET),
    .issue_valid (issue_valid),
    .issue_addr  (issue_addr),
    .issue_wdata (issue_wdata),
    .issue_wstrb (issue_wstrb),
    .bank_valid  (bank_valid),
    .bank_rdata  (bank_rdata)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // output side
  // ~~~~~~~~~~~~~~~~~~~~

  mem_response_stage response_stage0 (
    .CLOCK_CPU   (CLOCK_CPU),
    .RESET       (RESET),
    .issue_valid (issue_valid),
    .bank_valid  (bank_valid),
    .bank_rdata  (bank_rdata),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .busy        (busy)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 8,
  parameter int DRIVE_DELAY  = 10
) (
  output logic CLOCK_CPU,
  output logic RESET
);

  initial begin
    CLOCK_CPU = 1'b0;
    forever #(PERIOD / 2) CLOCK_CPU = ~CLOCK_CPU;
  end

  // active low, released just after an edge like any other input
  initial begin
    RESET = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLOCK_CPU);
    #DRIVE_DELAY;
    RESET = 1'b1;
  end

endmodule

// ==== verif/mem_system_sva.sv ====
`timescale 1ns/1ps

module mem_system_sva (
  input logic CLOCK_CPU,
  input logic RESET,
  input logic issue_valid,
  input logic mem_ready,
  input logic busy
);

  // ~~~~~~~~~~~~~~~~~~~~
  // after reset
  // ~~~~~~~~~~~~~~~~~~~~

  no_early_ready : assert property (@(posedge CLOCK_CPU) disable iff (!RESET)
    (!$past(RESET, 1) || !$past(RESET, 2) || !$past(RESET, 3) || !$past(RESET, 4))
      |-> !mem_ready)
    else $error("mem_ready high within 4 cycles of reset release");

  // ~~~~~~~~~~~~~~~~~~~~
  // per request
  // ~~~~~~~~~~~~~~~~~~~~

  // issue_valid marks the cycle after acceptance
  // busy must hold from there until the ready cycle
  busy_after_accept : assert property (@(posedge CLOCK_CPU) disable iff (!RESET)
    (issue_valid || $past(issue_valid, 1) || $past(issue_valid, 2) || $past(issue_valid, 3))
      |-> busy)
    else $error("busy low while an accepted request is still in flight");

  // each accepted request gives one ready cycle 4 cycles later
  ready_strobe : assert property (@(posedge CLOCK_CPU) disable iff (!RESET)
    mem_ready == $past(issue_valid, 3))
    else $error("mem_ready does not match a request accepted 4 cycles before");

endmodule

// ==== verif/mem_system_tb.sv ====
`timescale 1ns/1ps

`include "mem_macros.svh"

module mem_system_tb;

  import mem_pkg::*;

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY  = 10;
  localparam int LATENCY      = 4;
  localparam int N_POOL       = 16;
  localparam int N_PARTIAL    = 16;
  localparam int N_STREAM     = 64;
  localparam int N_LED        = 8;
  localparam int TOTAL_REQUESTS = 2 + 2 * N_POOL + N_PARTIAL + N_POOL + N_STREAM + N_LED;
  localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * 10 + RESET_CYCLES;

  logic     CLOCK_CPU;
  logic     RESET;
  logic     mem_valid;
  logic     mem_instr;
  addr_type mem_addr;
  word_type mem_wdata;
  strb_type mem_wstrb;
  logic     mem_ready;
  word_type mem_rdata;
  led_type  led;
  logic     busy;

  integer   seed = 32'hcd0edd4e;
  word_type model_mem [1024];
  addr_type pool [N_POOL];
  word_type exp_data_q [$];
  int       exp_cycle_q [$];
  led_type  expected_led = '0;
  int       cycle_count = 0;
  int       edges_since_release = 0;
  int       checks = 0;
  int       errors = 0;

  tb_clock_gen #(
    .PERIOD       (PERIOD),
    .RESET_CYCLES (RESET_CYCLES),
    .DRIVE_DELAY  (DRIVE_DELAY)
  ) clock_gen0 (
    .CLOCK_CPU (CLOCK_CPU),
    .RESET     (RESET)
  );

  mem_system dut0 (
    .CLOCK_CPU (CLOCK_CPU),
    .RESET     (RESET),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .led       (led),
    .busy      (busy)
  );

  bind mem_system mem_system_sva sva0 (
    .CLOCK_CPU   (CLOCK_CPU),
    .RESET       (RESET),
    .issue_valid (issue_valid),
    .mem_ready   (mem_ready),
    .busy        (busy)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~

  // word index is addr[11:2], any strobe bit makes it a write
  function automatic word_type model_access(input addr_type addr, input word_type wdata,
                                            input strb_type wstrb);
    logic [9:0] idx;
    word_type   result;
    idx = addr[11:2];
    if (wstrb != '0) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
      end
      result = '0;
    end else begin
      result = model_mem[idx];
    end
    return result;
  endfunction

  function automatic word_type rand_word();
    return $random(seed);
  endfunction

  // sampling edge, inputs are stable here
  always @(posedge CLOCK_CPU) begin
    cycle_count = cycle_count + 1;
    if (RESET) edges_since_release = edges_since_release + 1;
    if (RESET && mem_valid && edges_since_release > `CLEAR_CYCLES) begin
      exp_data_q.push_back(model_access(mem_addr, mem_wdata, mem_wstrb));
      exp_cycle_q.push_back(cycle_count);
      expected_led = mem_addr[18:3];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // compare
  // ~~~~~~~~~~~~~~~~~~~~

  always @(negedge CLOCK_CPU) begin
    word_type exp_data;
    int       exp_cycle;
    if (RESET) begin
      checks += 2;
      assert (busy == (exp_data_q.size() != 0)) else begin
        $display("[FAIL] %0t: busy is %b with %0d requests outstanding",
                 $time, busy, exp_data_q.size());
        errors++;
      end
      assert (led == expected_led) else begin
        $display("[FAIL] %0t: led %h, expected %h", $time, led, expected_led);
        errors++;
      end
      if (mem_ready) begin
        checks++;
        assert (exp_data_q.size() != 0) else begin
          $display("response at %0t arrived with no request outstanding", $time);
          errors++;
        end
        if (exp_data_q.size() != 0) begin
          exp_data  = exp_data_q.pop_front();
          exp_cycle = exp_cycle_q.pop_front();
          checks += 2;
          assert (mem_rdata == exp_data) else begin
            $display("[FAIL] %0t: rdata %h, expected %h", $time, mem_rdata, exp_data);
            errors++;
          end
          // ready is taken by the next rising edge
          assert (cycle_count + 1 - exp_cycle == LATENCY) else begin
            $display("[FAIL] %0t: latency %0d cycles, expected %0d",
                     $time, cycle_count + 1 - exp_cycle, LATENCY);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("watchdog expired after %0d cycles, responses stopped coming", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  // one request, held for a single sampling edge
  task automatic send_request(input addr_type addr, input word_type wdata,
                              input strb_type wstrb, input logic instr);
    mem_valid = 1'b1;
    mem_instr = instr;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    @(posedge CLOCK_CPU);
    #DRIVE_DELAY;
    mem_valid = 1'b0;
  endtask

  task automatic wait_idle(input int n);
    repeat (n) begin
      @(posedge CLOCK_CPU);
      #DRIVE_DELAY;
    end
  endtask

  task automatic drain_responses();
    while (exp_data_q.size() != 0) @(posedge CLOCK_CPU);
    wait_idle(2);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  initial begin
    word_type   w;
    addr_type   a;
    strb_type   s;
    logic [3:0] k;
    int         errs_before;
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    wait (RESET == 1'b1);

    // both land in the clear window
    errs_before = errors;
    send_request(32'h0007_fff8, 32'hdead_beef, 4'hf, 1'b0);
    send_request(32'h0000_1238, 32'h1234_5678, 4'hf, 1'b0);
    wait_idle(6);
    checks++;
    assert (led == '0) else begin
      $display("[FAIL] %0t: led %h after dropped requests", $time, led);
      errors++;
    end
    report_test("clear window", errs_before);

    errs_before = errors;
    for (int i = 0; i < N_POOL; i++) begin
      w = rand_word();
      pool[i] = {w[31:2], 2'b00};
      send_request(pool[i], rand_word(), 4'hf, 1'b0);
    end
    for (int i = 0; i < N_POOL; i++) send_request(pool[i], '0, '0, 1'b0);
    drain_responses();
    report_test("write read back", errs_before);

    errs_before = errors;
    for (int i = 0; i < N_PARTIAL; i++) begin
      w = rand_word();
      k = w[7:4];
      s = w[3:0];
      if (s == '0) s = 4'b0001;  // keep it a write
      send_request(pool[k], rand_word(), s, 1'b0);
    end
    for (int i = 0; i < N_POOL; i++) send_request(pool[i], '0, '0, 1'b0);
    drain_responses();
    report_test("byte strobes", errs_before);

    errs_before = errors;
    for (int i = 0; i < N_STREAM; i++) begin
      w = rand_word();
      k = w[3:0];
      s = w[4] ? w[11:8] : 4'b0000;
      a = rand_word();
      a = {a[31:12], pool[k][11:0]};  // high bits alias
      send_request(a, rand_word(), s, w[5]);
    end
    drain_responses();
    report_test("back to back", errs_before);

    errs_before = errors;
    for (int i = 0; i < N_LED; i++) begin
      a = rand_word();
      a = {a[31:12], pool[i][11:0]};
      send_request(a, '0, '0, 1'b1);
      checks += 2;
      assert (led == a[18:3]) else begin
        $display("[FAIL] %0t: led %h, expected %h", $time, led, a[18:3]);
        errors++;
      end
      assert (busy) else begin
        $display("[FAIL] %0t: busy low after an accepted request", $time);
        errors++;
      end
      drain_responses();
      checks++;
      assert (!busy) else begin
        $display("[FAIL] %0t: busy still high with nothing outstanding", $time);
        errors++;
      end
    end
    report_test("led and busy", errs_before);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/mem_pkg.sv
src/mem_request_stage.sv
src/mem_bank.sv
src/mem_response_stage.sv
src/mem_system.sv
verif/tb_clock_gen.sv
verif/mem_system_sva.sv
verif/mem_system_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory path testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module mem_system_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vmem_system_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# decided by the testbench's own verdict line
echo "$output" | grep -qx "Testbench passed"
if [ $? -ne 0 ]; then
  exit 1
fi
exit 0
